// File: hw/fpsu_pkg.sv
/*
  shared widths, float constants, flag layout and latency for the
  packed single-precision unit, plus the lane opcode and exception enums
*/
`default_nettype none

package fpsu_pkg;

  // one single-precision value and one packed operand
  localparam int SP_W  = 32;
  localparam int VEC_W = 64;

  // ieee single fields
  localparam int EXP_W    = 8;
  localparam int MAN_W    = 23;
  localparam int EXP_BIAS = 127;

  // canonical quiet nan
  localparam logic [SP_W-1:0] QNAN = 32'h7FC00000;

  // bit 0 invalid, bit 1 overflow
  localparam int FLAG_W = 2;

  // issue to retire, in cycles
  localparam int LANE_LAT = 3;

  // lane 1 opcodes
  typedef enum logic [2:0] {
    FADD  = 3'd0,
    FSUB  = 3'd1,
    FRSUB = 3'd2,
    FAND  = 3'd3,
    FOR   = 3'd4,
    FXOR  = 3'd5,
    FANDN = 3'd6
  } fadd_op_t;

  // lane 2 opcodes
  typedef enum logic [1:0] {
    FMUL    = 2'd0,
    FMUL_LO = 2'd1,
    FSWAP   = 2'd2,
    FDUP    = 2'd3
  } fmul_op_t;

  // reported exception, invalid has priority
  typedef enum logic [1:0] {
    EXC_NONE     = 2'd0,
    EXC_INVALID  = 2'd1,
    EXC_OVERFLOW = 2'd2
  } exc_code_t;

endpackage

`default_nettype wire

// File: hw/fadd_lane.sv
/*
  lane 1: packed single add, subtract, reverse subtract and 64-bit logic ops
  operand, result and output registers, round toward zero, denormals flushed
*/
`default_nettype none

module fadd_lane (
  input  wire logic                        clk,
  input  wire logic                        rst,
  input  wire logic                        en,
  input  wire fpsu_pkg::fadd_op_t          op,
  input  wire logic [fpsu_pkg::VEC_W-1:0]  a,
  input  wire logic [fpsu_pkg::VEC_W-1:0]  b,
  output logic      [fpsu_pkg::VEC_W-1:0]  res,
  output logic      [fpsu_pkg::FLAG_W-1:0] flags,
  output logic                             valid
);

  logic [fpsu_pkg::VEC_W-1:0]  a_q;
  logic [fpsu_pkg::VEC_W-1:0]  b_q;
  fpsu_pkg::fadd_op_t          op_q;
  logic                        v_q;
  logic [fpsu_pkg::VEC_W-1:0]  res_q;
  logic [fpsu_pkg::FLAG_W-1:0] flags_q;
  logic                        v2_q;

  logic [fpsu_pkg::SP_W-1:0]   half_res [2];
  logic [fpsu_pkg::FLAG_W-1:0] half_fl [2];
  logic [fpsu_pkg::VEC_W-1:0]  res_d;
  logic [fpsu_pkg::FLAG_W-1:0] flags_d;
  logic                        is_sub;
  logic                        is_rsub;

  // leading zeros of the 27-bit raw sum
  function automatic logic [4:0] lzc27(input logic [26:0] v);
    logic [4:0] n;
    n = 5'd27;
    for (int i = 0; i < 27; i++) begin
      if (v[i]) n = 5'(26 - i);
    end
    return n;
  endfunction

  assign is_sub  = (op_q == fpsu_pkg::FSUB) || (op_q == fpsu_pkg::FRSUB);
  assign is_rsub = (op_q == fpsu_pkg::FRSUB);

  for (genvar h = 0; h < 2; h++) begin : g_half
    logic [fpsu_pkg::SP_W-1:0]   x;
    logic [fpsu_pkg::SP_W-1:0]   y;
    logic                        xs, ys, rs;
    logic [fpsu_pkg::EXP_W-1:0]  xe, ye, big_e, small_e, shamt;
    logic [fpsu_pkg::MAN_W-1:0]  xm, ym, big_m, small_m;
    logic                        x_nan, y_nan, x_inf, y_inf, x_zero, y_zero;
    logic                        swap, eff_sub;
    logic [26:0]                 big_sig, small_sig, mag, norm;
    logic [4:0]                  lz;
    int                          re;
    logic [fpsu_pkg::SP_W-1:0]   r;
    logic [fpsu_pkg::FLAG_W-1:0] fl;

    // frsub is b - a, so swap the operands before negating y
    assign x = is_rsub ? b_q[h*fpsu_pkg::SP_W +: fpsu_pkg::SP_W]
                       : a_q[h*fpsu_pkg::SP_W +: fpsu_pkg::SP_W];
    assign y = is_rsub ? a_q[h*fpsu_pkg::SP_W +: fpsu_pkg::SP_W]
                       : b_q[h*fpsu_pkg::SP_W +: fpsu_pkg::SP_W];

    assign xs = x[fpsu_pkg::SP_W-1];
    assign ys = y[fpsu_pkg::SP_W-1] ^ is_sub;
    assign xe = x[fpsu_pkg::MAN_W +: fpsu_pkg::EXP_W];
    assign ye = y[fpsu_pkg::MAN_W +: fpsu_pkg::EXP_W];
    assign xm = x[fpsu_pkg::MAN_W-1:0];
    assign ym = y[fpsu_pkg::MAN_W-1:0];

    assign x_nan  = (&xe) && (|xm);
    assign y_nan  = (&ye) && (|ym);
    assign x_inf  = (&xe) && !(|xm);
    assign y_inf  = (&ye) && !(|ym);
    // denormals count as zero
    assign x_zero = (xe == '0);
    assign y_zero = (ye == '0);

    // order by magnitude so the difference never goes negative
    assign swap    = {ye, ym} > {xe, xm};
    assign big_e   = swap ? ye : xe;
    assign big_m   = swap ? ym : xm;
    assign small_e = swap ? xe : ye;
    assign small_m = swap ? xm : ym;
    assign rs      = swap ? ys : xs;
    assign eff_sub = xs ^ ys;
    assign shamt   = big_e - small_e;

    // carry, hidden, fraction, two guard bits
    assign big_sig   = {1'b0, 1'b1, big_m, 2'b00};
    assign small_sig = {1'b0, 1'b1, small_m, 2'b00} >> shamt;
    assign mag       = eff_sub ? big_sig - small_sig : big_sig + small_sig;
    assign lz        = lzc27(mag);
    assign norm      = mag << lz;
    assign re        = int'(big_e) + 1 - int'(lz);

    always_comb begin
      fl = '0;
      if (x_nan || y_nan) begin
        r = fpsu_pkg::QNAN;
      end else if (x_inf && y_inf && eff_sub) begin
        r     = fpsu_pkg::QNAN;
        fl[0] = 1'b1;
      end else if (x_inf) begin
        r = {xs, {fpsu_pkg::EXP_W{1'b1}}, {fpsu_pkg::MAN_W{1'b0}}};
      end else if (y_inf) begin
        r = {ys, {fpsu_pkg::EXP_W{1'b1}}, {fpsu_pkg::MAN_W{1'b0}}};
      end else if (x_zero && y_zero) begin
        // -0 only when both zeros are negative
        r = {xs & ys, {(fpsu_pkg::SP_W-1){1'b0}}};
      end else if (y_zero) begin
        r = {xs, xe, xm};
      end else if (x_zero) begin
        r = {ys, ye, ym};
      end else if (mag == '0) begin
        r = '0;
      end else if (re >= 255) begin
        r     = {rs, {fpsu_pkg::EXP_W{1'b1}}, {fpsu_pkg::MAN_W{1'b0}}};
        fl[1] = 1'b1;
      end else if (re <= 0) begin
        r = {rs, {(fpsu_pkg::SP_W-1){1'b0}}};
      end else begin
        r = {rs, fpsu_pkg::EXP_W'(re), norm[25:3]};
      end
    end

    assign half_res[h] = r;
    assign half_fl[h]  = fl;
  end

  always_comb begin
    flags_d = '0;
    case (op_q)
      fpsu_pkg::FAND:  res_d = a_q & b_q;
      fpsu_pkg::FOR:   res_d = a_q | b_q;
      fpsu_pkg::FXOR:  res_d = a_q ^ b_q;
      // andn inverts a
      fpsu_pkg::FANDN: res_d = ~a_q & b_q;
      default: begin
        res_d   = {half_res[1], half_res[0]};
        flags_d = half_fl[1] | half_fl[0];
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (en) begin
      a_q  <= a;
      b_q  <= b;
      op_q <= op;
    end
    if (v_q) begin
      res_q   <= res_d;
      flags_q <= flags_d;
    end
    // output register
    if (v2_q) begin
      res   <= res_q;
      flags <= flags_q;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      v_q   <= 1'b0;
      v2_q  <= 1'b0;
      valid <= 1'b0;
    end else begin
      v_q   <= en;
      v2_q  <= v_q;
      valid <= v2_q;
    end
  end

  a_valid_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(valid));

endmodule

`default_nettype wire

// File: hw/fmul_lane.sv
/*
  lane 2: packed single multiply, low-half multiply and half permutes
  operand, result and output registers, round toward zero, denormals flushed
*/
`default_nettype none

module fmul_lane (
  input  wire logic                        clk,
  input  wire logic                        rst,
  input  wire logic                        en,
  input  wire fpsu_pkg::fmul_op_t          op,
  input  wire logic [fpsu_pkg::VEC_W-1:0]  a,
  input  wire logic [fpsu_pkg::VEC_W-1:0]  b,
  output logic      [fpsu_pkg::VEC_W-1:0]  res,
  output logic      [fpsu_pkg::FLAG_W-1:0] flags,
  output logic                             valid
);

  logic [fpsu_pkg::VEC_W-1:0]  a_q;
  logic [fpsu_pkg::VEC_W-1:0]  b_q;
  fpsu_pkg::fmul_op_t          op_q;
  logic                        v_q;
  logic [fpsu_pkg::VEC_W-1:0]  res_q;
  logic [fpsu_pkg::FLAG_W-1:0] flags_q;
  logic                        v2_q;

  logic [fpsu_pkg::SP_W-1:0]   half_res [2];
  logic [fpsu_pkg::FLAG_W-1:0] half_fl [2];
  logic [fpsu_pkg::VEC_W-1:0]  res_d;
  logic [fpsu_pkg::FLAG_W-1:0] flags_d;

  for (genvar h = 0; h < 2; h++) begin : g_half
    logic [fpsu_pkg::SP_W-1:0]   x;
    logic [fpsu_pkg::SP_W-1:0]   y;
    logic                        rs;
    logic [fpsu_pkg::EXP_W-1:0]  xe, ye;
    logic [fpsu_pkg::MAN_W-1:0]  xm, ym, pm;
    logic                        x_nan, y_nan, x_inf, y_inf, x_zero, y_zero;
    logic [47:0]                 pr;
    int                          re;
    logic [fpsu_pkg::SP_W-1:0]   r;
    logic [fpsu_pkg::FLAG_W-1:0] fl;

    assign x  = a_q[h*fpsu_pkg::SP_W +: fpsu_pkg::SP_W];
    assign y  = b_q[h*fpsu_pkg::SP_W +: fpsu_pkg::SP_W];
    assign rs = x[fpsu_pkg::SP_W-1] ^ y[fpsu_pkg::SP_W-1];
    assign xe = x[fpsu_pkg::MAN_W +: fpsu_pkg::EXP_W];
    assign ye = y[fpsu_pkg::MAN_W +: fpsu_pkg::EXP_W];
    assign xm = x[fpsu_pkg::MAN_W-1:0];
    assign ym = y[fpsu_pkg::MAN_W-1:0];

    assign x_nan  = (&xe) && (|xm);
    assign y_nan  = (&ye) && (|ym);
    assign x_inf  = (&xe) && !(|xm);
    assign y_inf  = (&ye) && !(|ym);
    assign x_zero = (xe == '0);
    assign y_zero = (ye == '0);

    // product of 1.x by 1.y lies in [1,4), so at most one shift
    assign pr = {1'b1, xm} * {1'b1, ym};
    assign pm = pr[47] ? pr[46:24] : pr[45:23];
    assign re = int'(xe) + int'(ye) - fpsu_pkg::EXP_BIAS + int'(pr[47]);

    always_comb begin
      fl = '0;
      if (x_nan || y_nan) begin
        r = fpsu_pkg::QNAN;
      end else if ((x_inf && y_zero) || (x_zero && y_inf)) begin
        r     = fpsu_pkg::QNAN;
        fl[0] = 1'b1;
      end else if (x_inf || y_inf) begin
        r = {rs, {fpsu_pkg::EXP_W{1'b1}}, {fpsu_pkg::MAN_W{1'b0}}};
      end else if (x_zero || y_zero) begin
        r = {rs, {(fpsu_pkg::SP_W-1){1'b0}}};
      end else if (re >= 255) begin
        r     = {rs, {fpsu_pkg::EXP_W{1'b1}}, {fpsu_pkg::MAN_W{1'b0}}};
        fl[1] = 1'b1;
      end else if (re <= 0) begin
        // underflow flushes to signed zero
        r = {rs, {(fpsu_pkg::SP_W-1){1'b0}}};
      end else begin
        r = {rs, fpsu_pkg::EXP_W'(re), pm};
      end
    end

    assign half_res[h] = r;
    assign half_fl[h]  = fl;
  end

  always_comb begin
    flags_d = '0;
    case (op_q)
      fpsu_pkg::FMUL: begin
        res_d   = {half_res[1], half_res[0]};
        flags_d = half_fl[1] | half_fl[0];
      end
      // high half of a passes through untouched
      fpsu_pkg::FMUL_LO: begin
        res_d   = {a_q[fpsu_pkg::VEC_W-1:fpsu_pkg::SP_W], half_res[0]};
        flags_d = half_fl[0];
      end
      fpsu_pkg::FSWAP: res_d = {a_q[fpsu_pkg::SP_W-1:0], a_q[fpsu_pkg::VEC_W-1:fpsu_pkg::SP_W]};
      default:         res_d = {a_q[fpsu_pkg::SP_W-1:0], a_q[fpsu_pkg::SP_W-1:0]};
    endcase
  end

  always_ff @(posedge clk) begin
    if (en) begin
      a_q  <= a;
      b_q  <= b;
      op_q <= op;
    end
    if (v_q) begin
      res_q   <= res_d;
      flags_q <= flags_d;
    end
    // output register
    if (v2_q) begin
      res   <= res_q;
      flags <= flags_q;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      v_q   <= 1'b0;
      v2_q  <= 1'b0;
      valid <= 1'b0;
    end else begin
      v_q   <= en;
      v2_q  <= v_q;
      valid <= v2_q;
    end
  end

  a_op_legal: assert property (@(posedge clk) disable iff (rst)
    en |-> op inside {fpsu_pkg::FMUL, fpsu_pkg::FMUL_LO, fpsu_pkg::FSWAP, fpsu_pkg::FDUP});

endmodule

`default_nettype wire

// File: hw/fpsu_retire.sv
/*
  retire stage: result registers for both lanes, masked exception
  report per lane and the sticky status word
*/
`default_nettype none

module fpsu_retire (
  input  wire logic                        clk,
  input  wire logic                        rst,
  input  wire logic [fpsu_pkg::FLAG_W-1:0] exc_mask,
  input  wire logic [fpsu_pkg::VEC_W-1:0]  u1_res_in,
  input  wire logic [fpsu_pkg::VEC_W-1:0]  u2_res_in,
  input  wire logic [fpsu_pkg::FLAG_W-1:0] u1_flags,
  input  wire logic [fpsu_pkg::FLAG_W-1:0] u2_flags,
  input  wire logic                        u1_valid_in,
  input  wire logic                        u2_valid_in,
  output logic      [fpsu_pkg::VEC_W-1:0]  u1_res,
  output logic      [fpsu_pkg::VEC_W-1:0]  u2_res,
  output logic                             u1_valid,
  output logic                             u2_valid,
  output logic                             u1_ret_en,
  output logic                             u2_ret_en,
  output fpsu_pkg::exc_code_t              u1_ret,
  output fpsu_pkg::exc_code_t              u2_ret,
  output logic      [fpsu_pkg::FLAG_W-1:0] status
);

  logic [fpsu_pkg::FLAG_W-1:0] u1_raised;
  logic [fpsu_pkg::FLAG_W-1:0] u2_raised;
  logic [fpsu_pkg::FLAG_W-1:0] u1_enabled;
  logic [fpsu_pkg::FLAG_W-1:0] u2_enabled;

  // invalid wins over overflow
  function automatic fpsu_pkg::exc_code_t encode(input logic [fpsu_pkg::FLAG_W-1:0] f);
    if (f[0]) return fpsu_pkg::EXC_INVALID;
    if (f[1]) return fpsu_pkg::EXC_OVERFLOW;
    return fpsu_pkg::EXC_NONE;
  endfunction

  // flags only count on a valid result
  assign u1_raised  = {fpsu_pkg::FLAG_W{u1_valid_in}} & u1_flags;
  assign u2_raised  = {fpsu_pkg::FLAG_W{u2_valid_in}} & u2_flags;
  assign u1_enabled = u1_raised & exc_mask;
  assign u2_enabled = u2_raised & exc_mask;

  always_ff @(posedge clk) begin
    u1_res <= u1_res_in;
    u2_res <= u2_res_in;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      u1_valid  <= 1'b0;
      u2_valid  <= 1'b0;
      u1_ret_en <= 1'b0;
      u2_ret_en <= 1'b0;
      u1_ret    <= fpsu_pkg::EXC_NONE;
      u2_ret    <= fpsu_pkg::EXC_NONE;
      status    <= '0;
    end else begin
      u1_valid  <= u1_valid_in;
      u2_valid  <= u2_valid_in;
      u1_ret_en <= |u1_enabled;
      u2_ret_en <= |u2_enabled;
      u1_ret    <= encode(u1_enabled);
      u2_ret    <= encode(u2_enabled);
      // sticky, masked flags included
      status    <= status | u1_raised | u2_raised;
    end
  end

  a_u1_ret_valid: assert property (@(posedge clk) disable iff (rst) u1_ret_en |-> u1_valid);
  a_u2_ret_valid: assert property (@(posedge clk) disable iff (rst) u2_ret_en |-> u2_valid);

endmodule

`default_nettype wire

// File: hw/fpsu.sv
/*
  dual-lane packed single fpu top: add/logic lane, multiply/permute lane
  and the shared retire stage
*/
`default_nettype none

module fpsu (
  input  wire logic                        clk,
  input  wire logic                        rst,
  input  wire logic                        u1_en,
  input  wire fpsu_pkg::fadd_op_t          u1_op,
  input  wire logic [fpsu_pkg::VEC_W-1:0]  u1_a,
  input  wire logic [fpsu_pkg::VEC_W-1:0]  u1_b,
  input  wire logic                        u2_en,
  input  wire fpsu_pkg::fmul_op_t          u2_op,
  input  wire logic [fpsu_pkg::VEC_W-1:0]  u2_a,
  input  wire logic [fpsu_pkg::VEC_W-1:0]  u2_b,
  input  wire logic [fpsu_pkg::FLAG_W-1:0] exc_mask,
  output logic      [fpsu_pkg::VEC_W-1:0]  u1_res,
  output logic                             u1_valid,
  output fpsu_pkg::exc_code_t              u1_ret,
  output logic                             u1_ret_en,
  output logic      [fpsu_pkg::VEC_W-1:0]  u2_res,
  output logic                             u2_valid,
  output fpsu_pkg::exc_code_t              u2_ret,
  output logic                             u2_ret_en,
  output logic      [fpsu_pkg::FLAG_W-1:0] status
);

  logic [fpsu_pkg::VEC_W-1:0]  u1_lane_res;
  logic [fpsu_pkg::VEC_W-1:0]  u2_lane_res;
  logic [fpsu_pkg::FLAG_W-1:0] u1_lane_flags;
  logic [fpsu_pkg::FLAG_W-1:0] u2_lane_flags;
  logic                        u1_lane_valid;
  logic                        u2_lane_valid;

  fadd_lane u_fadd (
    .clk(clk), .rst(rst), .en(u1_en), .op(u1_op), .a(u1_a), .b(u1_b),
    .res(u1_lane_res), .flags(u1_lane_flags), .valid(u1_lane_valid)
  );

  fmul_lane u_fmul (
    .clk(clk), .rst(rst), .en(u2_en), .op(u2_op), .a(u2_a), .b(u2_b),
    .res(u2_lane_res), .flags(u2_lane_flags), .valid(u2_lane_valid)
  );

  fpsu_retire u_retire (
    .clk(clk), .rst(rst), .exc_mask(exc_mask),
    .u1_res_in(u1_lane_res), .u2_res_in(u2_lane_res),
    .u1_flags(u1_lane_flags), .u2_flags(u2_lane_flags),
    .u1_valid_in(u1_lane_valid), .u2_valid_in(u2_lane_valid),
    .u1_res(u1_res), .u2_res(u2_res),
    .u1_valid(u1_valid), .u2_valid(u2_valid),
    .u1_ret_en(u1_ret_en), .u2_ret_en(u2_ret_en),
    .u1_ret(u1_ret), .u2_ret(u2_ret),
    .status(status)
  );

endmodule

`default_nettype wire

// File: testbench/tb_fpsu.sv
/*
  testbench for the packed single fpu: directed float rows, random
  logic and permute rows, per-result latency, report and status checks
*/
`default_nettype none

module tb_fpsu;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_DIRECTED = 10;
  localparam int N_RANDOM   = 16;
  localparam int N_ROWS     = N_DIRECTED + N_RANDOM;
  localparam int CYC_LIMIT  = N_ROWS + fpsu_pkg::LANE_LAT + 20;

  logic clk;
  logic rst;
  logic u1_en;
  logic u2_en;
  fpsu_pkg::fadd_op_t u1_op;
  fpsu_pkg::fmul_op_t u2_op;
  logic [63:0] u1_a, u1_b, u2_a, u2_b;
  logic [1:0] exc_mask;
  logic [63:0] u1_res, u2_res;
  logic u1_valid, u2_valid, u1_ret_en, u2_ret_en;
  fpsu_pkg::exc_code_t u1_ret, u2_ret;
  logic [1:0] status;

  // stimulus and expected values, one row per issue cycle
  fpsu_pkg::fadd_op_t op1_t [N_ROWS];
  fpsu_pkg::fmul_op_t op2_t [N_ROWS];
  logic [63:0] a1_t [N_ROWS], b1_t [N_ROWS], res1_t [N_ROWS];
  logic [63:0] a2_t [N_ROWS], b2_t [N_ROWS], res2_t [N_ROWS];
  logic [1:0]  flg1_t [N_ROWS], flg2_t [N_ROWS], mask_t [N_ROWS];

  int q1_idx[$], q1_due[$], q2_idx[$], q2_due[$];
  int n_rows;
  int cyc;
  int value_errs;
  int other_errs;
  logic [31:0] rng_state;
  logic [1:0]  exp_status;

  fpsu UUT (
    .clk(clk), .rst(rst),
    .u1_en(u1_en), .u1_op(u1_op), .u1_a(u1_a), .u1_b(u1_b),
    .u2_en(u2_en), .u2_op(u2_op), .u2_a(u2_a), .u2_b(u2_b), .exc_mask(exc_mask),
    .u1_res(u1_res), .u1_valid(u1_valid), .u1_ret(u1_ret), .u1_ret_en(u1_ret_en),
    .u2_res(u2_res), .u2_valid(u2_valid), .u2_ret(u2_ret), .u2_ret_en(u2_ret_en),
    .status(status)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cyc = cyc + 1;
    if (cyc > CYC_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYC_LIMIT);
      $display("Result: FAILED");
      $finish;
    end
  end

  function logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // enabled flags select the report, invalid first
  function automatic fpsu_pkg::exc_code_t expected_report(input logic [1:0] f,
                                                          input logic [1:0] m);
    if ((f & m) == 2'b00) return fpsu_pkg::EXC_NONE;
    else if (f[0] && m[0]) return fpsu_pkg::EXC_INVALID;
    else return fpsu_pkg::EXC_OVERFLOW;
  endfunction

  function automatic logic [63:0] bitwise_result(input fpsu_pkg::fadd_op_t op,
                                                 input logic [63:0] a, input logic [63:0] b);
    case (op)
      fpsu_pkg::FAND: return a & b;
      fpsu_pkg::FOR:  return a | b;
      fpsu_pkg::FXOR: return a ^ b;
      default:        return ~a & b;
    endcase
  endfunction

  function automatic logic [63:0] permuted(input fpsu_pkg::fmul_op_t op, input logic [63:0] a);
    if (op == fpsu_pkg::FSWAP) return {a[31:0], a[63:32]};
    else return {a[31:0], a[31:0]};
  endfunction

  task automatic add_row(input fpsu_pkg::fadd_op_t o1, input logic [63:0] a1, input logic [63:0] b1,
                         input logic [63:0] r1, input logic [1:0] f1,
                         input fpsu_pkg::fmul_op_t o2, input logic [63:0] a2,
                         input logic [63:0] b2, input logic [63:0] r2,
                         input logic [1:0] f2, input logic [1:0] m);
    op1_t[n_rows]  = o1;
    a1_t[n_rows]   = a1;
    b1_t[n_rows]   = b1;
    res1_t[n_rows] = r1;
    flg1_t[n_rows] = f1;
    op2_t[n_rows]  = o2;
    a2_t[n_rows]   = a2;
    b2_t[n_rows]   = b2;
    res2_t[n_rows] = r2;
    flg2_t[n_rows] = f2;
    mask_t[n_rows] = m;
    n_rows++;
  endtask

  task automatic build_table();
    logic [63:0] ra, rb, rc;
    logic [31:0] sel;
    fpsu_pkg::fadd_op_t o1;
    fpsu_pkg::fmul_op_t o2;
    // exact sums and products
    add_row(fpsu_pkg::FADD, 64'h3FC00000_40400000, 64'h40100000_3F000000,
            64'h40700000_40600000, 2'b00, fpsu_pkg::FMUL, 64'h40400000_C0000000,
            64'h3F000000_3FC00000, 64'h3FC00000_C0400000, 2'b00, 2'b11);
    add_row(fpsu_pkg::FSUB, 64'h40A00000_3F800000, 64'h40000000_40800000,
            64'h40400000_C0400000, 2'b00, fpsu_pkg::FMUL_LO, 64'h40E00000_40200000,
            64'h3F800000_40800000, 64'h40E00000_41200000, 2'b00, 2'b11);
    add_row(fpsu_pkg::FRSUB, 64'h3F800000_3E800000, 64'h40200000_3F800000,
            64'h3FC00000_3F400000, 2'b00, fpsu_pkg::FSWAP, 64'h11223344_55667788,
            64'h0, 64'h55667788_11223344, 2'b00, 2'b11);
    // denormal operands act as zero
    add_row(fpsu_pkg::FADD, 64'h00400000_40000000, 64'h3FC00000_00000001,
            64'h3FC00000_40000000, 2'b00, fpsu_pkg::FDUP, 64'hDEADBEEF_01234567,
            64'h0, 64'h01234567_01234567, 2'b00, 2'b11);
    // inexact results truncate toward zero
    add_row(fpsu_pkg::FSUB, 64'h3F800000_3F800000, 64'hB3800000_33000000,
            64'h3F800000_3F7FFFFF, 2'b00, fpsu_pkg::FMUL, 64'h3F000000_3FC00000,
            64'h3F000000_3F800001, 64'h3E800000_3FC00001, 2'b00, 2'b11);
    // inf-inf on lane 1, product overflow on lane 2, both enabled
    add_row(fpsu_pkg::FSUB, 64'h7F800000_3F800000, 64'h7F800000_3F800000,
            64'h7FC00000_00000000, 2'b01, fpsu_pkg::FMUL, 64'h7F000000_FF000000,
            64'h40000000_40800000, 64'h7F800000_FF800000, 2'b10, 2'b11);
    // nan inputs quietly, 0*inf with invalid enabled
    add_row(fpsu_pkg::FADD, 64'h7FC12345_3F800000, 64'h3F800000_FFFFFFFF,
            64'h7FC00000_7FC00000, 2'b00, fpsu_pkg::FMUL, 64'h00000000_40000000,
            64'h7F800000_40400000, 64'h7FC00000_40C00000, 2'b01, 2'b01);
    // same exceptions, all masked
    add_row(fpsu_pkg::FADD, 64'h7F800000_FF800000, 64'hFF800000_3F800000,
            64'h7FC00000_FF800000, 2'b01, fpsu_pkg::FMUL, 64'h7F000000_3F800000,
            64'h7F000000_00000000, 64'h7F800000_00000000, 2'b10, 2'b00);
    add_row(fpsu_pkg::FAND, 64'hF0F0F0F0_12345678, 64'hFF00FF00_0F0F0F0F,
            64'hF000F000_02040608, 2'b00, fpsu_pkg::FMUL, 64'h7F800000_7F000000,
            64'h00000000_7F000000, 64'h7FC00000_7F800000, 2'b11, 2'b11);
    // high-half overflow is ignored by the low-half multiply
    add_row(fpsu_pkg::FANDN, 64'hF0F0F0F0_0000FFFF, 64'hFFFFFFFF_12345678,
            64'h0F0F0F0F_12340000, 2'b00, fpsu_pkg::FMUL_LO, 64'h7F000000_40400000,
            64'h7F000000_3F000000, 64'h7F000000_3FC00000, 2'b00, 2'b11);
    for (int k = 0; k < N_RANDOM; k++) begin
      ra[31:0]  = next_rand();
      ra[63:32] = next_rand();
      rb[31:0]  = next_rand();
      rb[63:32] = next_rand();
      rc[31:0]  = next_rand();
      rc[63:32] = next_rand();
      sel       = next_rand();
      case (sel[17:16])
        2'd0:    o1 = fpsu_pkg::FAND;
        2'd1:    o1 = fpsu_pkg::FOR;
        2'd2:    o1 = fpsu_pkg::FXOR;
        default: o1 = fpsu_pkg::FANDN;
      endcase
      o2 = sel[20] ? fpsu_pkg::FSWAP : fpsu_pkg::FDUP;
      add_row(o1, ra, rb, bitwise_result(o1, ra, rb), 2'b00,
              o2, rc, rb, permuted(o2, rc), 2'b00, sel[25:24]);
    end
  endtask

  task automatic pop_entry(input int lane, output int idx, output int due);
    if (lane == 1) begin
      idx = q1_idx.pop_front();
      due = q1_due.pop_front();
    end else begin
      idx = q2_idx.pop_front();
      due = q2_due.pop_front();
    end
  endtask

  task automatic check_lane(input int lane, input logic vld, input logic [63:0] got,
                            input logic got_en, input fpsu_pkg::exc_code_t got_ret);
    int idx;
    int due;
    logic have;
    logic [63:0] exp_res;
    logic [1:0] exp_flg;
    fpsu_pkg::exc_code_t exp_ret;
    have = (lane == 1) ? (q1_idx.size() > 0) : (q2_idx.size() > 0);
    if (!vld) begin
      assert (!got_en) else begin
        value_errs++;
        $display("[FAIL] %0t: lane %0d ret_en high without valid", $time, lane);
      end
      due = (lane == 1) ? (have ? q1_due[0] : cyc + 1) : (have ? q2_due[0] : cyc + 1);
      assert (due > cyc) else begin
        other_errs++;
        $display("lane %0d result due in cycle %0d never arrived", lane, due);
        pop_entry(lane, idx, due);
      end
    end else begin
      assert (have) else begin
        other_errs++;
        $display("lane %0d signalled valid at %0t with nothing in flight", lane, $time);
      end
      if (have) begin
        pop_entry(lane, idx, due);
        assert (due == cyc) else begin
          other_errs++;
          $display("lane %0d row %0d arrived in cycle %0d instead of %0d", lane, idx, cyc, due);
        end
        exp_res = (lane == 1) ? res1_t[idx] : res2_t[idx];
        exp_flg = (lane == 1) ? flg1_t[idx] : flg2_t[idx];
        exp_ret = expected_report(exp_flg, mask_t[idx]);
        assert (got == exp_res) else begin
          value_errs++;
          $display("[FAIL] %0t: lane %0d row %0d result %h, expected %h",
                   $time, lane, idx, got, exp_res);
        end
        assert (got_en == |(exp_flg & mask_t[idx])) else begin
          value_errs++;
          $display("[FAIL] %0t: lane %0d row %0d ret_en %b", $time, lane, idx, got_en);
        end
        assert (got_ret == exp_ret) else begin
          value_errs++;
          $display("[FAIL] %0t: lane %0d row %0d ret %s, expected %s", $time, lane, idx,
                   got_ret.name(), exp_ret.name());
        end
        exp_status = exp_status | exp_flg;
      end
    end
  endtask

  // outputs settle after the rising edge, so compare on the falling one
  always @(negedge clk) begin
    if (!rst) begin
      check_lane(1, u1_valid, u1_res, u1_ret_en, u1_ret);
      check_lane(2, u2_valid, u2_res, u2_ret_en, u2_ret);
      assert (status == exp_status) else begin
        value_errs++;
        $display("[FAIL] %0t: status %b, expected %b", $time, status, exp_status);
      end
    end
  end

  task automatic issue_row(input int i);
    u1_en = 1'b1;
    u1_op = op1_t[i];
    u1_a  = a1_t[i];
    u1_b  = b1_t[i];
    u2_en = 1'b1;
    u2_op = op2_t[i];
    u2_a  = a2_t[i];
    u2_b  = b2_t[i];
    q1_idx.push_back(i);
    q1_due.push_back(cyc + 1 + fpsu_pkg::LANE_LAT);
    q2_idx.push_back(i);
    q2_due.push_back(cyc + 1 + fpsu_pkg::LANE_LAT);
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    u1_en = 1'b0;
    u1_op = fpsu_pkg::FADD;
    u1_a = '0;
    u1_b = '0;
    u2_en = 1'b0;
    u2_op = fpsu_pkg::FMUL;
    u2_a = '0;
    u2_b = '0;
    exc_mask = 2'b00;
    cyc = 0;
    n_rows = 0;
    value_errs = 0;
    other_errs = 0;
    exp_status = 2'b00;
    rng_state = 32'd5;
    build_table();
    repeat (2) @(posedge clk);
    #2 rst = 1'b0;
    for (int i = 0; i < N_ROWS + fpsu_pkg::LANE_LAT; i++) begin
      @(posedge clk);
      #2;
      if (i < N_ROWS) begin
        issue_row(i);
      end else begin
        u1_en = 1'b0;
        u2_en = 1'b0;
      end
      // the mask is sampled at retire, three rows behind issue
      if (i >= fpsu_pkg::LANE_LAT) exc_mask = mask_t[i - fpsu_pkg::LANE_LAT];
    end
    while (q1_idx.size() != 0 || q2_idx.size() != 0) @(posedge clk);
    repeat (2) @(posedge clk);
    $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
    if (value_errs + other_errs == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: fpsu.f
hw/fpsu_pkg.sv
hw/fadd_lane.sv
hw/fmul_lane.sv
hw/fpsu_retire.sv
hw/fpsu.sv
testbench/tb_fpsu.sv

// File: Bender.yml
package:
  name: fpsu

sources:
  - hw/fpsu_pkg.sv
  - hw/fadd_lane.sv
  - hw/fmul_lane.sv
  - hw/fpsu_retire.sv
  - hw/fpsu.sv
  - target: test
    files:
      - testbench/tb_fpsu.sv
